//--- src.f
+incdir+common
common/bp_pkg.sv
common/bp_update_if.sv
predictor/btb.sv
predictor/bp_direction.sv
predictor/bp_cfg_regs.sv
predictor/branch_predictor.sv
verif/bp_sva.sv
verif/tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# Build and run the predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_branch_predictor \
    -Mdir obj_dir

./obj_dir/Vtb_branch_predictor

//--- verif/tb_branch_predictor.sv
// ====================
// Table-driven run checked against a reference model of every table
// Stops at the first mismatch
// ====================

`timescale 1ns/1ps

`include "bp_params.svh"

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int ACK_TIMEOUT = 20;

    typedef enum logic [1:0] {
        ST_UPDATE,
        ST_WRITE,
        ST_READ,
        ST_PROBE
    } step_kind_e;

    // One row of stimulus plus expected response
    typedef struct packed {
        step_kind_e kind;
        addr_t      pc;
        addr_t      target;
        logic       is_br;
        logic       taken;
        cfg_addr_e  addr;
        logic [2:0] wdata;
        logic       exp_hit;
        addr_t      exp_target;
        logic       exp_taken;
        bp_mode_e   exp_mode;
        logic       exp_en;
    } step_t;

    logic       clk_i;
    logic       rst_ni;
    addr_t      pc_i;
    logic       btb_hit_o;
    addr_t      target_o;
    logic       taken_o;
    logic       upd_valid_i;
    logic       upd_is_branch_i;
    logic       upd_taken_i;
    addr_t      upd_pc_i;
    addr_t      upd_target_i;
    logic       cfg_req_i;
    logic       cfg_we_i;
    cfg_addr_e  cfg_addr_i;
    logic [2:0] cfg_wdata_i;
    logic       cfg_ack_o;
    logic [2:0] cfg_rdata_o;

    step_t       steps[$];

    // ====================
    // Reference model
    // ====================

    ctr2_t      m_bim [`BP_PHT_ENTRIES];
    ctr2_t      m_gsh [`BP_PHT_ENTRIES];
    ctr2_t      m_cho [`BP_PHT_ENTRIES];
    logic [7:0] m_ghr;
    logic       m_valid [`BP_BTB_ENTRIES];
    addr_t      m_tag [`BP_BTB_ENTRIES];
    addr_t      m_tgt [`BP_BTB_ENTRIES];
    bp_mode_e   m_mode;
    logic       m_en;

    branch_predictor u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Counter moves one step toward the outcome, held at 0 and 3
    function automatic ctr2_t sat_toward(ctr2_t c, logic t);
        if (t) begin
            return (c == 2'd3) ? c : ctr2_t'(c + 2'd1);
        end
        return (c == 2'd0) ? c : ctr2_t'(c - 2'd1);
    endfunction

    // State after reset or flush
    function automatic void clear_model();
        for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
            m_bim[i] = 2'd1;
            m_gsh[i] = 2'd1;
            m_cho[i] = 2'd1;
        end
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_tgt[i]   = '0;
        end
        m_ghr = '0;
    endfunction

    function automatic logic model_taken(addr_t pc);
        logic [7:0] bi;
        logic [7:0] gi;
        bi = pc[9:2];
        gi = bi ^ m_ghr;
        case (m_mode)
            BIMODAL: return m_bim[bi][1];
            GSHARE:  return m_gsh[gi][1];
            default: return m_cho[bi][1] ? m_gsh[gi][1] : m_bim[bi][1];
        endcase
    endfunction

    // Training, all decisions from the state before the edge
    function automatic void train_model(addr_t pc, addr_t tgt, logic t);
        logic [7:0] bi;
        logic [7:0] gi;
        logic [5:0] bt;
        logic       bim_right;
        logic       gsh_right;
        bi        = pc[9:2];
        gi        = bi ^ m_ghr;
        bt        = pc[7:2];
        bim_right = (m_bim[bi][1] == t);
        gsh_right = (m_gsh[gi][1] == t);
        m_bim[bi] = sat_toward(m_bim[bi], t);
        m_gsh[gi] = sat_toward(m_gsh[gi], t);
        if (gsh_right && !bim_right) begin
            m_cho[bi] = sat_toward(m_cho[bi], 1'b1);
        end else if (bim_right && !gsh_right) begin
            m_cho[bi] = sat_toward(m_cho[bi], 1'b0);
        end
        m_ghr = {m_ghr[6:0], t};
        if (t) begin
            m_valid[bt] = 1'b1;
            m_tag[bt]   = pc;
            m_tgt[bt]   = tgt;
        end
    endfunction

    // ====================
    // Table builders
    // ====================

    // Random upper bits, fixed index bits
    function automatic addr_t pick_pc(logic [7:0] idx);
        logic [31:0] r;
        r = $urandom;
        return {r[31:10], idx, 2'b00};
    endfunction

    function automatic addr_t pick_target();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    task automatic add_update(addr_t pc, addr_t tgt, logic is_br, logic t);
        step_t s;
        s        = '0;
        s.kind   = ST_UPDATE;
        s.pc     = pc;
        s.target = tgt;
        s.is_br  = is_br;
        s.taken  = t;
        steps.push_back(s);
        if (is_br) begin
            train_model(pc, tgt, t);
        end
    endtask

    task automatic add_probe(addr_t pc);
        step_t s;
        s            = '0;
        s.kind       = ST_PROBE;
        s.pc         = pc;
        s.exp_hit    = m_en && m_valid[pc[7:2]] && (m_tag[pc[7:2]] == pc);
        s.exp_target = m_tgt[pc[7:2]];
        s.exp_taken  = model_taken(pc);
        steps.push_back(s);
    endtask

    task automatic add_cfg(step_kind_e kind, cfg_addr_e addr, logic [2:0] wdata);
        step_t s;
        s       = '0;
        s.kind  = kind;
        s.addr  = addr;
        s.wdata = wdata;
        if (kind == ST_WRITE && addr == CFG_CTRL) begin
            m_mode = bp_mode_e'(wdata[1:0]);
            m_en   = wdata[2];
        end else if (kind == ST_WRITE && wdata[0]) begin
            clear_model();
        end
        // FLUSH reads back as zero
        s.exp_mode = (addr == CFG_CTRL) ? m_mode : BIMODAL;
        s.exp_en   = (addr == CFG_CTRL) ? m_en : 1'b0;
        steps.push_back(s);
    endtask

    task automatic build_table();
        addr_t pc_a;
        addr_t pc_b;
        addr_t pc_c;
        addr_t pc_d;
        addr_t pc_e;
        addr_t pc_g;
        addr_t pc_h;
        pc_a = pick_pc(8'h03);
        // Same index, other upper bits
        pc_b = pc_a ^ 32'h0010_0000;
        pc_c = pick_pc(8'h07);
        pc_d = pick_pc(8'h20);
        pc_e = pick_pc(8'h40);
        pc_g = pick_pc(8'h5A);
        pc_h = pick_pc(8'h11);
        // BTB learning, aliasing, not-taken and non-branch updates
        add_probe(pc_a);
        add_update(pc_a, pick_target(), 1'b1, 1'b1);
        add_probe(pc_a);
        add_update(pc_b, pick_target(), 1'b1, 1'b1);
        add_probe(pc_a);
        add_probe(pc_b);
        add_update(pc_c, pick_target(), 1'b1, 1'b0);
        add_update(pc_c, pick_target(), 1'b0, 1'b1);
        add_probe(pc_c);
        // Bimodal 1 to 2, then saturate back
        add_cfg(ST_WRITE, CFG_CTRL, {1'b1, BIMODAL});
        add_cfg(ST_READ, CFG_CTRL, 3'd0);
        add_update(pc_d, pick_target(), 1'b1, 1'b1);
        add_probe(pc_d);
        repeat (3) add_update(pc_d, pick_target(), 1'b1, 1'b0);
        add_probe(pc_d);
        // gshare under changing history
        add_cfg(ST_WRITE, CFG_CTRL, {1'b1, GSHARE});
        add_cfg(ST_READ, CFG_CTRL, 3'd0);
        repeat (2) add_update(pc_e, pick_target(), 1'b1, 1'b1);
        add_probe(pc_e);
        add_update(pc_c, pick_target(), 1'b1, 1'b0);
        add_probe(pc_c);
        add_probe(pc_e);
        // Tournament, bimodal trained not-taken under history 00
        add_cfg(ST_WRITE, CFG_CTRL, {1'b1, TOURNAMENT});
        repeat (8) add_update(pc_h, pick_target(), 1'b1, 1'b0);
        repeat (2) add_update(pc_g, pick_target(), 1'b1, 1'b0);
        // History FF, gshare right and bimodal wrong on the second
        repeat (8) add_update(pc_h, pick_target(), 1'b1, 1'b1);
        add_update(pc_g, pick_target(), 1'b1, 1'b1);
        add_probe(pc_g);
        add_update(pc_g, pick_target(), 1'b1, 1'b1);
        add_probe(pc_g);
        // Back to history 00, chooser now follows gshare
        repeat (8) add_update(pc_h, pick_target(), 1'b1, 1'b0);
        add_probe(pc_g);
        // BTB enable and flush
        add_cfg(ST_WRITE, CFG_CTRL, {1'b0, TOURNAMENT});
        add_cfg(ST_READ, CFG_CTRL, 3'd0);
        add_probe(pc_b);
        add_cfg(ST_WRITE, CFG_CTRL, {1'b1, TOURNAMENT});
        add_probe(pc_b);
        add_cfg(ST_WRITE, CFG_FLUSH, 3'b001);
        add_cfg(ST_READ, CFG_FLUSH, 3'd0);
        add_probe(pc_b);
        add_probe(pc_h);
        add_cfg(ST_READ, CFG_CTRL, 3'd0);
    endtask

    // ====================
    // Compare tasks
    // ====================

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic check_mode(bp_mode_e got, bp_mode_e exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout: %s within %0d cycles", what, ACK_TIMEOUT);
        $display("Simulation failed");
        $fatal(1, "Handshake timeout");
    endtask

    // ====================
    // Step drivers
    // ====================

    task automatic drive_update(step_t s);
        @(posedge clk_i);
        #1;
        upd_valid_i     = 1'b1;
        upd_is_branch_i = s.is_br;
        upd_taken_i     = s.taken;
        upd_pc_i        = s.pc;
        upd_target_i    = s.target;
        @(posedge clk_i);
        #1;
        upd_valid_i     = 1'b0;
        upd_is_branch_i = 1'b0;
    endtask

    // Outputs are combinational, sampled mid-cycle
    task automatic probe(int n, step_t s);
        @(posedge clk_i);
        #1;
        pc_i = s.pc;
        #4;
        check_bit(btb_hit_o, s.exp_hit, $sformatf("step %0d btb_hit_o", n));
        if (s.exp_hit) begin
            check_addr(target_o, s.exp_target, $sformatf("step %0d target_o", n));
        end
        check_bit(taken_o, s.exp_taken, $sformatf("step %0d taken_o", n));
    endtask

    task automatic cfg_access(int n, step_t s);
        int cycles;
        @(posedge clk_i);
        #1;
        cfg_req_i   = 1'b1;
        cfg_we_i    = (s.kind == ST_WRITE);
        cfg_addr_i  = s.addr;
        cfg_wdata_i = s.wdata;
        cycles      = 0;
        while (!cfg_ack_o) begin
            if (cycles == ACK_TIMEOUT) begin
                report_timeout("cfg_ack_o did not rise");
            end else begin
                @(posedge clk_i);
                #1;
                cycles++;
            end
        end
        if (s.kind == ST_READ) begin
            check_mode(bp_mode_e'(cfg_rdata_o[1:0]), s.exp_mode,
                       $sformatf("step %0d read mode", n));
            check_bit(cfg_rdata_o[2], s.exp_en, $sformatf("step %0d read btb_en", n));
        end
        cfg_req_i = 1'b0;
        cycles    = 0;
        while (cfg_ack_o) begin
            if (cycles == ACK_TIMEOUT) begin
                report_timeout("cfg_ack_o did not fall");
            end else begin
                @(posedge clk_i);
                #1;
                cycles++;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        void'($urandom(32'h698b));
        rst_ni          = 1'b0;
        pc_i            = '0;
        upd_valid_i     = 1'b0;
        upd_is_branch_i = 1'b0;
        upd_taken_i     = 1'b0;
        upd_pc_i        = '0;
        upd_target_i    = '0;
        cfg_req_i       = 1'b0;
        cfg_we_i        = 1'b0;
        cfg_addr_i      = CFG_CTRL;
        cfg_wdata_i     = '0;
        m_mode          = TOURNAMENT;
        m_en            = 1'b1;
        clear_model();
        build_table();
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            case (steps[i].kind)
                ST_UPDATE: drive_update(steps[i]);
                ST_PROBE:  probe(i, steps[i]);
                default:   cfg_access(i, steps[i]);
            endcase
        end
        $display("Simulation passed");
        $finish;
    end

endmodule : tb_branch_predictor

//--- verif/bp_sva.sv
// ====================
// Bound into branch_predictor, btb_en taken from the internal wire
// ====================

`timescale 1ns/1ps

module bp_sva (
    input logic          clk_i,
    input logic          rst_ni,
    input logic          cfg_req_i,
    input logic          cfg_ack_o,
    input logic [2:0]    cfg_rdata_o,
    input logic          btb_en_i,
    input logic          btb_hit_o,
    input logic          taken_o,
    input bp_pkg::addr_t target_o
);

    // ====================
    // Handshake
    // ====================

    ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(cfg_ack_o) |-> $past(cfg_req_i))
        else $error("cfg_ack_o rose without cfg_req_i");

    // ack may only drop after req has gone low
    ack_holds_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(cfg_ack_o) |-> !$past(cfg_req_i))
        else $error("cfg_ack_o fell while cfg_req_i was high");

    // ====================
    // Prediction outputs
    // ====================

    hit_needs_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !btb_en_i |-> !btb_hit_o)
        else $error("btb_hit_o high while the BTB is disabled");

    outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown({btb_hit_o, taken_o, cfg_ack_o, cfg_rdata_o}))
        else $error("Unknown value on a predictor output");

    // Target is only meaningful on a hit
    target_known_on_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        btb_hit_o |-> !$isunknown(target_o))
        else $error("target_o unknown on a BTB hit");

endmodule : bp_sva

bind branch_predictor bp_sva u_sva (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_req_i   (cfg_req_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .btb_en_i    (btb_en),
    .btb_hit_o   (btb_hit_o),
    .taken_o     (taken_o),
    .target_o    (target_o)
);

//--- predictor/branch_predictor.sv
// ====================
// Same-cycle prediction from pc_i, updates land at the next edge
// No back-pressure on the update port
// ====================

`timescale 1ns/1ps

module branch_predictor (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Prediction
    input  bp_pkg::addr_t      pc_i,
    output logic               btb_hit_o,
    output bp_pkg::addr_t      target_o,
    output logic               taken_o,
    // Resolved branch from execute
    input  logic               upd_valid_i,
    input  logic               upd_is_branch_i,
    input  logic               upd_taken_i,
    input  bp_pkg::addr_t      upd_pc_i,
    input  bp_pkg::addr_t      upd_target_i,
    // Config port
    input  logic               cfg_req_i,
    input  logic               cfg_we_i,
    input  bp_pkg::cfg_addr_e  cfg_addr_i,
    input  logic [2:0]         cfg_wdata_i,
    output logic               cfg_ack_o,
    output logic [2:0]         cfg_rdata_o
);

    import bp_pkg::*;

    // Control from the register block
    bp_mode_e mode;
    logic     btb_en;
    logic     flush;

    // Update bus, driven from the plain ports
    bp_update_if u_upd ();

    assign u_upd.valid     = upd_valid_i;
    assign u_upd.is_branch = upd_is_branch_i;
    assign u_upd.taken     = upd_taken_i;
    assign u_upd.pc        = upd_pc_i;
    assign u_upd.target    = upd_target_i;

    // Target lookup
    btb u_btb (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pc_i     (pc_i),
        .btb_en_i (btb_en),
        .flush_i  (flush),
        .upd      (u_upd.sink),
        .hit_o    (btb_hit_o),
        .target_o (target_o)
    );

    // Direction lookup
    bp_direction u_dir (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .pc_i    (pc_i),
        .mode_i  (mode),
        .flush_i (flush),
        .upd     (u_upd.sink),
        .taken_o (taken_o)
    );

    // Settings block
    bp_cfg_regs u_cfg (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_req_i   (cfg_req_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .mode_o      (mode),
        .btb_en_o    (btb_en),
        .flush_o     (flush)
    );

endmodule : branch_predictor

//--- predictor/bp_cfg_regs.sv
// ====================
// Four-phase req/ack, ack follows req by one cycle
// Master must wait for ack low before a new request
// ====================

`timescale 1ns/1ps

module bp_cfg_regs (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               cfg_req_i,
    input  logic               cfg_we_i,
    input  bp_pkg::cfg_addr_e  cfg_addr_i,
    input  logic [2:0]         cfg_wdata_i,
    output logic               cfg_ack_o,
    output logic [2:0]         cfg_rdata_o,
    output bp_pkg::bp_mode_e   mode_o,
    output logic               btb_en_o,
    output logic               flush_o
);

    import bp_pkg::*;

    logic       ack_q;
    logic [2:0] rdata_q;
    bp_mode_e   mode_q;
    logic       btb_en_q;
    logic       flush_q;

    // New request seen, ack still low
    logic       req_new;

    assign req_new = cfg_req_i && !ack_q;

    // ====================
    // Handshake and registers
    // ====================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q    <= 1'b0;
            rdata_q  <= '0;
            mode_q   <= TOURNAMENT;
            btb_en_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            // Rises after req, falls after req drops
            ack_q   <= cfg_req_i;
            // Pulse lasts only one cycle
            flush_q <= 1'b0;
            if (req_new) begin
                if (cfg_we_i) begin
                    if (cfg_addr_i == CFG_CTRL) begin
                        mode_q   <= bp_mode_e'(cfg_wdata_i[1:0]);
                        btb_en_q <= cfg_wdata_i[2];
                    end else begin
                        flush_q  <= cfg_wdata_i[0];
                    end
                end
                // Read data reflects the register after this access
                if (cfg_addr_i == CFG_CTRL) begin
                    rdata_q <= cfg_we_i ? cfg_wdata_i : {btb_en_q, mode_q};
                end else begin
                    // FLUSH reads as zero
                    rdata_q <= '0;
                end
            end
        end
    end

    // ====================
    // Outputs
    // ====================

    assign cfg_ack_o   = ack_q;
    assign cfg_rdata_o = rdata_q;
    assign mode_o      = mode_q;
    assign btb_en_o    = btb_en_q;
    assign flush_o     = flush_q;

endmodule : bp_cfg_regs

//--- predictor/bp_direction.sv
// ====================
// Bimodal + gshare + chooser, history trained only by resolved branches
// All updates use table state from before the clock edge
// ====================

`timescale 1ns/1ps

`include "bp_params.svh"

module bp_direction (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bp_pkg::addr_t     pc_i,
    input  bp_pkg::bp_mode_e  mode_i,
    input  logic              flush_i,
    bp_update_if.sink         upd,
    output logic              taken_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(`BP_PHT_ENTRIES);

    // Saturating step toward the given direction
    function automatic ctr2_t ctr_step(ctr2_t c, logic up);
        ctr2_t n;
        n = c;
        if (up && (c != 2'd3)) begin
            n = c + 2'd1;
        end else if (!up && (c != 2'd0)) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    // ====================
    // Tables and history
    // ====================

    ctr2_t bim_q [`BP_PHT_ENTRIES];
    ctr2_t gsh_q [`BP_PHT_ENTRIES];
    // Chooser high half selects gshare
    ctr2_t cho_q [`BP_PHT_ENTRIES];

    // Newest outcome in bit 0
    logic [`BP_GHR_W-1:0] ghr_q;

    // Prediction side
    logic [IDX_W-1:0] rd_bim_idx;
    logic [IDX_W-1:0] rd_gsh_idx;
    ctr2_t            bim_ctr;
    ctr2_t            gsh_ctr;
    ctr2_t            cho_ctr;

    // Update side
    logic             upd_fire;
    logic [IDX_W-1:0] wr_bim_idx;
    logic [IDX_W-1:0] wr_gsh_idx;
    logic             bim_ok;
    logic             gsh_ok;

    // ====================
    // Lookup
    // ====================

    // Bimodal and chooser share an index
    assign rd_bim_idx = pc_i[IDX_W+1:2];
    assign rd_gsh_idx = pc_i[IDX_W+1:2] ^ ghr_q;

    assign bim_ctr = bim_q[rd_bim_idx];
    assign gsh_ctr = gsh_q[rd_gsh_idx];
    assign cho_ctr = cho_q[rd_bim_idx];

    // Direction by mode
    always_comb begin
        case (mode_i)
            BIMODAL: taken_o = bim_ctr[1];
            GSHARE:  taken_o = gsh_ctr[1];
            // Tournament, and the unused code 3
            default: taken_o = cho_ctr[1] ? gsh_ctr[1] : bim_ctr[1];
        endcase
    end

    // ====================
    // Training
    // ====================

    assign upd_fire   = upd.valid && upd.is_branch;
    assign wr_bim_idx = upd.pc[IDX_W+1:2];
    // History before this update's shift
    assign wr_gsh_idx = upd.pc[IDX_W+1:2] ^ ghr_q;

    // Was each table right for this branch
    assign bim_ok = (bim_q[wr_bim_idx][1] == upd.taken);
    assign gsh_ok = (gsh_q[wr_gsh_idx][1] == upd.taken);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                bim_q[i] <= CTR_INIT;
                gsh_q[i] <= CTR_INIT;
                cho_q[i] <= CTR_INIT;
            end
            ghr_q <= '0;
        end else if (flush_i) begin
            // Flush beats a same-cycle update
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                bim_q[i] <= CTR_INIT;
                gsh_q[i] <= CTR_INIT;
                cho_q[i] <= CTR_INIT;
            end
            ghr_q <= '0;
        end else if (upd_fire) begin
            bim_q[wr_bim_idx] <= ctr_step(bim_q[wr_bim_idx], upd.taken);
            gsh_q[wr_gsh_idx] <= ctr_step(gsh_q[wr_gsh_idx], upd.taken);
            // Chooser moves only when the tables disagree in outcome
            if (gsh_ok && !bim_ok) begin
                cho_q[wr_bim_idx] <= ctr_step(cho_q[wr_bim_idx], 1'b1);
            end else if (bim_ok && !gsh_ok) begin
                cho_q[wr_bim_idx] <= ctr_step(cho_q[wr_bim_idx], 1'b0);
            end
            // Shift in resolved outcome
            ghr_q <= {ghr_q[`BP_GHR_W-2:0], upd.taken};
        end
    end

endmodule : bp_direction

//--- predictor/btb.sv
// ====================
// Direct-mapped, full-pc tag, lookup is combinational
// Flush wins over a same-cycle update
// ====================

`timescale 1ns/1ps

`include "bp_params.svh"

module btb #(
    parameter int ENTRIES = `BP_BTB_ENTRIES
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  bp_pkg::addr_t  pc_i,
    input  logic           btb_en_i,
    input  logic           flush_i,
    bp_update_if.sink      upd,
    output logic           hit_o,
    output bp_pkg::addr_t  target_o
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    // ====================
    // Storage
    // ====================

    // Entry valid bits
    logic  valid_q  [ENTRIES];
    // Full-pc tag and predicted target per entry
    addr_t tag_q    [ENTRIES];
    addr_t target_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;

    // Word-aligned index, skip the two low bits
    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = upd.pc[IDX_W+1:2];

    // Only taken branches allocate
    assign wr_en = upd.valid && upd.is_branch && upd.taken;

    // ====================
    // Lookup
    // ====================

    // Whole pc compared, no partial-tag aliasing
    assign hit_o    = btb_en_i && valid_q[rd_idx] && (tag_q[rd_idx] == pc_i);
    assign target_o = target_q[rd_idx];

    // Valid bits, cleared by reset and flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target write, replaces any aliasing entry
    always_ff @(posedge clk_i) begin
        if (wr_en && !flush_i) begin
            tag_q[wr_idx]    <= upd.pc;
            target_q[wr_idx] <= upd.target;
        end
    end

endmodule : btb

//--- common/bp_update_if.sv
// ====================
// One resolved branch per cycle, no back-pressure
// Update counts only when valid and is_branch are both high
// ====================

`timescale 1ns/1ps

interface bp_update_if;

    import bp_pkg::*;

    // Update qualifiers
    logic  valid;
    logic  is_branch;
    logic  taken;

    // Branch pc and its resolved target
    addr_t pc;
    addr_t target;

    // Driven by the predictor top from execute
    modport source (
        output valid,
        output is_branch,
        output taken,
        output pc,
        output target
    );

    // Read by the BTB and the direction tables
    modport sink (
        input valid,
        input is_branch,
        input taken,
        input pc,
        input target
    );

endinterface : bp_update_if

//--- common/bp_pkg.sv
// ====================
// Shared predictor types
// Counter encoding: 2 and 3 mean taken, chooser high half picks gshare
// ====================

`include "bp_params.svh"

package bp_pkg;

    // Instruction address
    typedef logic [`BP_ADDR_W-1:0] addr_t;

    // 2-bit saturating counter
    typedef logic [1:0] ctr2_t;

    // Weakly not-taken, also weakly bimodal for the chooser
    localparam ctr2_t CTR_INIT = 2'd1;

    // Direction source select
    // Value 3 falls back to tournament
    typedef enum logic [1:0] {
        BIMODAL    = 2'd0,
        GSHARE     = 2'd1,
        TOURNAMENT = 2'd2
    } bp_mode_e;

    // Config register map
    // CTRL holds mode in [1:0] and btb_en in [2]
    // FLUSH is write-only, bit 0 requests a flush
    typedef enum logic {
        CFG_CTRL  = 1'b0,
        CFG_FLUSH = 1'b1
    } cfg_addr_e;

endpackage : bp_pkg

//--- common/bp_params.svh
// ====================
// Table sizes must be powers of two
// BP_GHR_W must equal log2 of BP_PHT_ENTRIES for the gshare XOR
// ====================

`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Instruction address width
`define BP_ADDR_W 32

// Direct-mapped BTB depth
`define BP_BTB_ENTRIES 64

// Bimodal, gshare and chooser depth
`define BP_PHT_ENTRIES 256

// Global history length
`define BP_GHR_W 8

`endif
